// ==== Bender.yml ====
package:
  name: wb_subsys

sources:
  - files:
      - rtl/wb_subsys_pkg.sv
      - rtl/wb_bus_if.sv
      - rtl/wb_addr_decoder.sv
      - rtl/data_ram.sv
      - rtl/irq_capture.sv
      - rtl/irq_regs.sv
      - rtl/gpio_regs.sv
      - rtl/wb_subsys_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_wb_subsys.sv

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int DEPTH = 1024
) (
    input logic     clk_i,
    wb_bus_if.slave bus
);
    import wb_subsys_pkg::*;

    localparam int IDX_W  = $clog2(DEPTH);
    localparam int LANE_W = DATA_W / SEL_W;

    word_t            mem [DEPTH];
    word_t            dat_q;
    logic             ack_q;
    logic             req;
    logic [IDX_W-1:0] idx;

    // First cycle of a strobe only
    assign req = bus.cyc & bus.stb & ~ack_q;
    assign idx = bus.adr[IDX_W-1:0];

    always_ff @(posedge clk_i) begin
        ack_q <= req;
        if (req) begin
            dat_q <= mem[idx];
            if (bus.we) begin
                for (int i = 0; i < SEL_W; i++) begin
                    if (bus.sel[i]) begin
                        mem[idx][i*LANE_W +: LANE_W] <= bus.dat_w[i*LANE_W +: LANE_W];
                    end
                end
            end
        end
    end

    assign bus.dat_r = dat_q;
    assign bus.ack   = ack_q;
    assign bus.err   = 1'b0;

    a_ack_after_stb : assert property (
        @(posedge clk_i) $rose(bus.ack) |-> $past(bus.cyc && bus.stb)
    );

endmodule

// ==== rtl/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs #(
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             reset_i,
    wb_bus_if.slave          bus,
    input  logic [WIDTH-1:0] pins_i,
    output logic [WIDTH-1:0] pins_o,
    output logic [WIDTH-1:0] oe_o
);
    import wb_subsys_pkg::*;

    logic [WIDTH-1:0] out_q;
    logic [WIDTH-1:0] dir_q;
    logic [WIDTH-1:0] sync1_q;
    logic [WIDTH-1:0] in_q;
    logic             ack_q;
    logic             req;
    logic             wr;
    off_t             off;
    word_t            rd_data;
    word_t            dat_q;

    assign req = bus.cyc & bus.stb & ~ack_q;
    assign wr  = req & bus.we;
    assign off = bus.adr[OFFS_W-1:0];

    // --------------------------------------------------
    // Control registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_q <= '0;
            dir_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
            if (wr && off == GPIO_OUT) begin
                out_q <= bus.dat_w[WIDTH-1:0];
            end
            if (wr && off == GPIO_DIR) begin
                dir_q <= bus.dat_w[WIDTH-1:0];
            end
        end
    end

    // Two-flop input synchroniser
    always_ff @(posedge clk_i) begin
        sync1_q <= pins_i;
        in_q    <= sync1_q;
    end

    always_comb begin
        rd_data = '0;
        case (off)
            GPIO_OUT: rd_data[WIDTH-1:0] = out_q;
            GPIO_DIR: rd_data[WIDTH-1:0] = dir_q;
            GPIO_IN:  rd_data[WIDTH-1:0] = in_q;
            default:  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            dat_q <= rd_data;
        end
    end

    assign bus.dat_r = dat_q;
    assign bus.ack   = ack_q;
    assign bus.err   = 1'b0;
    assign pins_o    = out_q;
    assign oe_o      = dir_q;

endmodule

// ==== rtl/irq_capture.sv ====
`timescale 1ns/1ps

module irq_capture #(
    parameter int SOURCES = 8
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [SOURCES-1:0]         src_i,
    input  logic [SOURCES-1:0]         armed_i,
    output logic [SOURCES-1:0]         edge_o,
    output logic [$clog2(SOURCES)-1:0] active_idx_o,
    output logic                       active_valid_o
);

    localparam int IDX_W = $clog2(SOURCES);

    logic [SOURCES-1:0] sync1_q;
    logic [SOURCES-1:0] sync2_q;
    logic [SOURCES-1:0] prev_q;

    // --------------------------------------------------
    // Synchroniser and edge detect
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= src_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    // One-cycle pulse per rising source
    assign edge_o = sync2_q & ~prev_q;

    // --------------------------------------------------
    // Priority encoder
    // --------------------------------------------------
    // Scan downwards so the lowest armed source wins
    always_comb begin
        active_idx_o   = '0;
        active_valid_o = 1'b0;
        for (int i = SOURCES - 1; i >= 0; i--) begin
            if (armed_i[i]) begin
                active_idx_o   = IDX_W'(i);
                active_valid_o = 1'b1;
            end
        end
    end

endmodule

// ==== rtl/irq_regs.sv ====
`timescale 1ns/1ps

module irq_regs #(
    parameter int SOURCES = 8
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    wb_bus_if.slave                    bus,
    input  logic [SOURCES-1:0]         edge_i,
    input  logic [$clog2(SOURCES)-1:0] active_idx_i,
    input  logic                       active_valid_i,
    output logic [SOURCES-1:0]         armed_o,
    output logic                       irq_o
);
    import wb_subsys_pkg::*;

    localparam int IDX_W = $clog2(SOURCES);

    logic [SOURCES-1:0] pending_q;
    logic [SOURCES-1:0] mask_q;
    logic [SOURCES-1:0] mask_d;
    logic [SOURCES-1:0] clear;
    logic               irq_q;
    logic               ack_q;
    logic               req;
    logic               wr;
    off_t               off;
    word_t              rd_data;
    word_t              dat_q;

    assign req = bus.cyc & bus.stb & ~ack_q;
    assign wr  = req & bus.we;
    assign off = bus.adr[OFFS_W-1:0];

    // Write-one-to-clear on the pending register
    assign clear  = (wr && off == IRQ_PENDING) ? bus.dat_w[SOURCES-1:0] : '0;
    assign mask_d = (wr && off == IRQ_MASK) ? bus.dat_w[SOURCES-1:0] : mask_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
            mask_q    <= '0;
            irq_q     <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            // New edge beats a clear in the same cycle
            pending_q <= (pending_q & ~clear) | edge_i;
            mask_q    <= mask_d;
            // Masking a bit drops irq in the same edge
            irq_q     <= |(pending_q & mask_q & mask_d);
            ack_q     <= req;
        end
    end

    // --------------------------------------------------
    // Read-back
    // --------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (off)
            IRQ_PENDING: rd_data[SOURCES-1:0] = pending_q;
            IRQ_MASK:    rd_data[SOURCES-1:0] = mask_q;
            IRQ_ACTIVE: begin
                rd_data[IDX_W-1:0]       = active_idx_i;
                rd_data[ACTIVE_VALID_BIT] = active_valid_i;
            end
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            dat_q <= rd_data;
        end
    end

    assign bus.dat_r = dat_q;
    assign bus.ack   = ack_q;
    assign bus.err   = 1'b0;
    assign armed_o   = pending_q & mask_q;
    assign irq_o     = irq_q;

    a_no_irq_masked : assert property (
        @(posedge clk_i) disable iff (reset_i) (mask_q == '0) |-> !irq_o
    );

endmodule

// ==== rtl/wb_addr_decoder.sv ====
`timescale 1ns/1ps

module wb_addr_decoder (
    input  logic     clk_i,
    input  logic     reset_i,
    wb_bus_if.slave  bus_m,
    wb_bus_if.master ram_s,
    wb_bus_if.master irq_s,
    wb_bus_if.master gpio_s
);
    import wb_subsys_pkg::*;

    region_t region;
    logic    hit_ram;
    logic    hit_irq;
    logic    hit_gpio;
    logic    unmapped;
    logic    err_q;

    assign region   = bus_m.adr[ADDR_W-1 -: REGION_W];
    assign hit_ram  = (region == REGION_RAM);
    assign hit_irq  = (region == REGION_IRQ);
    assign hit_gpio = (region == REGION_GPIO);
    assign unmapped = ~(hit_ram | hit_irq | hit_gpio);

    // --------------------------------------------------
    // Request fan-out with steered strobes
    // --------------------------------------------------
    assign ram_s.cyc   = bus_m.cyc;
    assign ram_s.stb   = bus_m.stb & hit_ram;
    assign ram_s.we    = bus_m.we;
    assign ram_s.sel   = bus_m.sel;
    assign ram_s.adr   = bus_m.adr;
    assign ram_s.dat_w = bus_m.dat_w;

    assign irq_s.cyc   = bus_m.cyc;
    assign irq_s.stb   = bus_m.stb & hit_irq;
    assign irq_s.we    = bus_m.we;
    assign irq_s.sel   = bus_m.sel;
    assign irq_s.adr   = bus_m.adr;
    assign irq_s.dat_w = bus_m.dat_w;

    assign gpio_s.cyc   = bus_m.cyc;
    assign gpio_s.stb   = bus_m.stb & hit_gpio;
    assign gpio_s.we    = bus_m.we;
    assign gpio_s.sel   = bus_m.sel;
    assign gpio_s.adr   = bus_m.adr;
    assign gpio_s.dat_w = bus_m.dat_w;

    // --------------------------------------------------
    // Response mux
    // --------------------------------------------------
    // Address is held until the reply, so the mux can follow it
    always_comb begin
        bus_m.dat_r = '0;
        bus_m.ack   = 1'b0;
        bus_m.err   = err_q;
        if (hit_ram) begin
            bus_m.dat_r = ram_s.dat_r;
            bus_m.ack   = ram_s.ack;
            bus_m.err   = ram_s.err;
        end else if (hit_irq) begin
            bus_m.dat_r = irq_s.dat_r;
            bus_m.ack   = irq_s.ack;
            bus_m.err   = irq_s.err;
        end else if (hit_gpio) begin
            bus_m.dat_r = gpio_s.dat_r;
            bus_m.ack   = gpio_s.ack;
            bus_m.err   = gpio_s.err;
        end
    end

    // One-cycle error reply to an unmapped access
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= bus_m.cyc & bus_m.stb & unmapped & ~err_q;
        end
    end

    a_ack_err_excl : assert property (
        @(posedge clk_i) disable iff (reset_i) !(bus_m.ack && bus_m.err)
    );

endmodule

// ==== rtl/wb_bus_if.sv ====
`timescale 1ns/1ps

interface wb_bus_if;
    import wb_subsys_pkg::*;

    // Request side
    logic  cyc;
    logic  stb;
    logic  we;
    sel_t  sel;
    adr_t  adr;
    word_t dat_w;

    // Response side
    word_t dat_r;
    logic  ack;
    logic  err;

    modport master (
        output cyc,
        output stb,
        output we,
        output sel,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack,
        input  err
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack,
        output err
    );

endinterface

// ==== rtl/wb_subsys_pkg.sv ====
package wb_subsys_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // Top address bits pick the slave, low bits pick a register
    localparam int REGION_W = 4;
    localparam int OFFS_W   = 2;

    typedef logic [ADDR_W-1:0]   adr_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [SEL_W-1:0]    sel_t;
    typedef logic [REGION_W-1:0] region_t;
    typedef logic [OFFS_W-1:0]   off_t;

    // --------------------------------------------------
    // Address map
    // --------------------------------------------------
    localparam region_t REGION_RAM  = 4'd0;
    localparam region_t REGION_IRQ  = 4'd1;
    localparam region_t REGION_GPIO = 4'd2;

    // Interrupt controller registers
    localparam off_t IRQ_PENDING = 2'd0;
    localparam off_t IRQ_MASK    = 2'd1;
    localparam off_t IRQ_ACTIVE  = 2'd2;

    // GPIO controller registers
    localparam off_t GPIO_OUT = 2'd0;
    localparam off_t GPIO_DIR = 2'd1;
    localparam off_t GPIO_IN  = 2'd2;

    // Marks a valid index in the active-source word
    localparam int ACTIVE_VALID_BIT = 8;

endpackage

// ==== rtl/wb_subsys_top.sv ====
`timescale 1ns/1ps

module wb_subsys_top #(
    parameter int RAM_DEPTH   = 1024,
    parameter int IRQ_SOURCES = 8,
    parameter int GPIO_W      = 8
) (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // Wishbone master side
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  wb_subsys_pkg::sel_t      wb_sel_i,
    input  wb_subsys_pkg::adr_t      wb_adr_i,
    input  wb_subsys_pkg::word_t     wb_dat_i,
    output wb_subsys_pkg::word_t     wb_dat_o,
    output logic                     wb_ack_o,
    output logic                     wb_err_o,

    // Interrupts and pins
    input  logic [IRQ_SOURCES-1:0]   irq_src_i,
    output logic                     irq_o,
    input  logic [GPIO_W-1:0]        gpio_i,
    output logic [GPIO_W-1:0]        gpio_o,
    output logic [GPIO_W-1:0]        gpio_oe_o
);

    wb_bus_if wb_m ();
    wb_bus_if wb_ram ();
    wb_bus_if wb_irq ();
    wb_bus_if wb_gpio ();

    logic [IRQ_SOURCES-1:0]         irq_edge;
    logic [IRQ_SOURCES-1:0]         irq_armed;
    logic [$clog2(IRQ_SOURCES)-1:0] irq_active_idx;
    logic                           irq_active_valid;

    // --------------------------------------------------
    // External master onto the bus
    // --------------------------------------------------
    assign wb_m.cyc   = wb_cyc_i;
    assign wb_m.stb   = wb_stb_i;
    assign wb_m.we    = wb_we_i;
    assign wb_m.sel   = wb_sel_i;
    assign wb_m.adr   = wb_adr_i;
    assign wb_m.dat_w = wb_dat_i;
    assign wb_dat_o   = wb_m.dat_r;
    assign wb_ack_o   = wb_m.ack;
    assign wb_err_o   = wb_m.err;

    wb_addr_decoder u_decoder (
        .clk_i   ( clk_i   ),
        .reset_i ( reset_i ),
        .bus_m   ( wb_m    ),
        .ram_s   ( wb_ram  ),
        .irq_s   ( wb_irq  ),
        .gpio_s  ( wb_gpio )
    );

    data_ram #(
        .DEPTH ( RAM_DEPTH )
    ) u_dmem (
        .clk_i ( clk_i  ),
        .bus   ( wb_ram )
    );

    // --------------------------------------------------
    // Interrupt controller
    // --------------------------------------------------
    irq_capture #(
        .SOURCES ( IRQ_SOURCES )
    ) u_irq_capture (
        .clk_i          ( clk_i            ),
        .reset_i        ( reset_i          ),
        .src_i          ( irq_src_i        ),
        .armed_i        ( irq_armed        ),
        .edge_o         ( irq_edge         ),
        .active_idx_o   ( irq_active_idx   ),
        .active_valid_o ( irq_active_valid )
    );

    irq_regs #(
        .SOURCES ( IRQ_SOURCES )
    ) u_irq_regs (
        .clk_i          ( clk_i            ),
        .reset_i        ( reset_i          ),
        .bus            ( wb_irq           ),
        .edge_i         ( irq_edge         ),
        .active_idx_i   ( irq_active_idx   ),
        .active_valid_i ( irq_active_valid ),
        .armed_o        ( irq_armed        ),
        .irq_o          ( irq_o            )
    );

    gpio_regs #(
        .WIDTH ( GPIO_W )
    ) u_gpio (
        .clk_i   ( clk_i     ),
        .reset_i ( reset_i   ),
        .bus     ( wb_gpio   ),
        .pins_i  ( gpio_i    ),
        .pins_o  ( gpio_o    ),
        .oe_o    ( gpio_oe_o )
    );

endmodule

// ==== sim/tb_wb_tasks.svh ====
// --------------------------------------------------
// Helpers and typed compares
// --------------------------------------------------
function automatic adr_t reg_adr(input region_t region, input int unsigned offset);
    return {region, (ADDR_W-REGION_W)'(offset)};
endfunction

// Byte-lane merge of a partial write over an old word
function automatic word_t merge_lanes(input word_t old_w, input word_t new_w, input sel_t sel);
    word_t m;
    m = old_w;
    for (int i = 0; i < SEL_W; i++) begin
        if (sel[i]) begin
            m[i*(DATA_W/SEL_W) +: DATA_W/SEL_W] = new_w[i*(DATA_W/SEL_W) +: DATA_W/SEL_W];
        end
    end
    return m;
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_pins(input string name, input logic [GPIO_W-1:0] got,
                          input logic [GPIO_W-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("MISMATCH %s: got 0x%02h, expected 0x%02h", name, got, exp));
    end
endtask

// --------------------------------------------------
// Bus access
// --------------------------------------------------
// Returns at a falling edge, so outputs are stable for the caller
task automatic bus_access(input adr_t adr, input logic we, input sel_t sel, input word_t wdat,
                          output word_t rdat, output logic ack, output logic err);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_sel_i <= sel;
    wb_adr_i <= adr;
    wb_dat_i <= wdat;
    do begin
        @(posedge clk_i);
        cycles++;
        @(negedge clk_i);
        ack = wb_ack_o;
        err = wb_err_o;
    end while (!ack && !err && cycles < MAX_WAIT);
    if (!ack && !err) begin
        fail_run($sformatf("No ack or err came back for the access to 0x%04h", adr));
    end
    if (cycles != 1) begin
        fail_run($sformatf("Access to 0x%04h answered after %0d cycles instead of 1",
                           adr, cycles));
    end
    rdat = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    // Reply is one cycle wide
    @(negedge clk_i);
    check_flag("wb_ack_o", wb_ack_o, 1'b0);
    check_flag("wb_err_o", wb_err_o, 1'b0);
endtask

task automatic wb_write(input adr_t adr, input sel_t sel, input word_t dat);
    word_t rd;
    logic  ack;
    logic  err;
    bus_access(adr, 1'b1, sel, dat, rd, ack, err);
    check_flag("wb_ack_o", ack, 1'b1);
endtask

task automatic wb_read(input adr_t adr, output word_t dat);
    logic ack;
    logic err;
    bus_access(adr, 1'b0, '1, '0, dat, ack, err);
    check_flag("wb_ack_o", ack, 1'b1);
endtask

// Reads until the expected value shows or the limit is hit
task automatic poll_read(input adr_t adr, input word_t exp, output word_t got);
    int tries;
    tries = 0;
    do begin
        wb_read(adr, got);
        tries++;
    end while (got !== exp && tries < POLL_LIMIT);
endtask

task automatic wait_irq(input logic exp);
    int n;
    n = 0;
    while (irq_o !== exp && n < POLL_LIMIT) begin
        @(negedge clk_i);
        n++;
    end
    check_flag("irq_o", irq_o, exp);
endtask

// --------------------------------------------------
// Directed tests
// --------------------------------------------------
task automatic test_reset_state();
    word_t rd;
    @(negedge clk_i);
    check_flag("irq_o", irq_o, 1'b0);
    check_flag("wb_ack_o", wb_ack_o, 1'b0);
    check_flag("wb_err_o", wb_err_o, 1'b0);
    check_pins("gpio_oe_o", gpio_oe_o, '0);
    wb_read(reg_adr(REGION_IRQ, IRQ_MASK), rd);
    check_word("IRQ_MASK", rd, '0);
    wb_read(reg_adr(REGION_IRQ, IRQ_PENDING), rd);
    check_word("IRQ_PENDING", rd, '0);
    wb_read(reg_adr(REGION_GPIO, GPIO_OUT), rd);
    check_word("GPIO_OUT", rd, '0);
    wb_read(reg_adr(REGION_GPIO, GPIO_DIR), rd);
    check_word("GPIO_DIR", rd, '0);
endtask

task automatic test_ram_lanes();
    sel_t  lanes [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101, 4'b0000};
    word_t merged [6];
    word_t first;
    word_t second;
    word_t rd;
    for (int i = 0; i < 6; i++) begin
        first = $random(seed);
        second = $random(seed);
        wb_write(reg_adr(REGION_RAM, 37 * i + 3), '1, first);
        wb_write(reg_adr(REGION_RAM, 37 * i + 3), lanes[i], second);
        merged[i] = merge_lanes(first, second, lanes[i]);
    end
    for (int i = 0; i < 6; i++) begin
        wb_read(reg_adr(REGION_RAM, 37 * i + 3), rd);
        check_word($sformatf("RAM word %0d", 37 * i + 3), rd, merged[i]);
    end
endtask

task automatic test_unmapped();
    word_t stored;
    word_t rd;
    logic  ack;
    logic  err;
    stored = $random(seed);
    wb_write(reg_adr(REGION_RAM, 100), '1, stored);
    bus_access(reg_adr(4'd3, 0), 1'b0, '1, '0, rd, ack, err);
    check_flag("wb_err_o", err, 1'b1);
    check_flag("wb_ack_o", ack, 1'b0);
    // Unmapped write must not reach the RAM
    bus_access(reg_adr(4'hf, 100), 1'b1, '1, ~stored, rd, ack, err);
    check_flag("wb_err_o", err, 1'b1);
    check_flag("wb_ack_o", ack, 1'b0);
    wb_read(reg_adr(REGION_RAM, 100), rd);
    check_word("RAM word 100", rd, stored);
endtask

task automatic test_gpio();
    logic [GPIO_W-1:0] out_v;
    logic [GPIO_W-1:0] dir_v;
    logic [GPIO_W-1:0] in_v;
    word_t             rd;
    out_v = GPIO_W'($random(seed));
    dir_v = GPIO_W'($random(seed));
    in_v  = GPIO_W'($random(seed));
    wb_write(reg_adr(REGION_GPIO, GPIO_OUT), '1, word_t'(out_v));
    wb_write(reg_adr(REGION_GPIO, GPIO_DIR), '1, word_t'(dir_v));
    check_pins("gpio_o", gpio_o, out_v);
    check_pins("gpio_oe_o", gpio_oe_o, dir_v);
    wb_write(reg_adr(REGION_GPIO, GPIO_IN), '1, '1);
    wb_read(reg_adr(REGION_GPIO, GPIO_OUT), rd);
    check_word("GPIO_OUT", rd, word_t'(out_v));
    wb_read(reg_adr(REGION_GPIO, GPIO_DIR), rd);
    check_word("GPIO_DIR", rd, word_t'(dir_v));
    @(posedge clk_i);
    gpio_i <= in_v;
    poll_read(reg_adr(REGION_GPIO, GPIO_IN), word_t'(in_v), rd);
    check_word("GPIO_IN", rd, word_t'(in_v));
endtask

task automatic test_interrupts();
    logic [IRQ_SOURCES-1:0] both;
    word_t                  valid_w;
    word_t                  rd;
    both    = '0;
    both[5] = 1'b1;
    both[2] = 1'b1;
    valid_w = word_t'(1) << ACTIVE_VALID_BIT;
    @(posedge clk_i);
    irq_src_i <= both;
    repeat (2) @(posedge clk_i);
    irq_src_i <= '0;
    // Masked sources latch but stay silent
    poll_read(reg_adr(REGION_IRQ, IRQ_PENDING), word_t'(both), rd);
    check_word("IRQ_PENDING", rd, word_t'(both));
    check_flag("irq_o", irq_o, 1'b0);
    wb_write(reg_adr(REGION_IRQ, IRQ_MASK), '1, word_t'(both));
    wait_irq(1'b1);
    wb_read(reg_adr(REGION_IRQ, IRQ_ACTIVE), rd);
    check_word("IRQ_ACTIVE", rd, valid_w | word_t'(2));
    wb_write(reg_adr(REGION_IRQ, IRQ_PENDING), '1, word_t'(1) << 2);
    wb_read(reg_adr(REGION_IRQ, IRQ_ACTIVE), rd);
    check_word("IRQ_ACTIVE", rd, valid_w | word_t'(5));
    check_flag("irq_o", irq_o, 1'b1);
    wb_write(reg_adr(REGION_IRQ, IRQ_PENDING), '1, word_t'(1) << 5);
    wait_irq(1'b0);
    wb_read(reg_adr(REGION_IRQ, IRQ_ACTIVE), rd);
    check_flag("IRQ_ACTIVE valid", rd[ACTIVE_VALID_BIT], 1'b0);
    wb_read(reg_adr(REGION_IRQ, IRQ_PENDING), rd);
    check_word("IRQ_PENDING", rd, '0);
endtask

// ==== sim/tb_wb_subsys.sv ====
`timescale 1ns/1ps

module tb_wb_subsys;
    import wb_subsys_pkg::*;

    localparam int RAM_DEPTH   = 1024;
    localparam int IRQ_SOURCES = 8;
    localparam int GPIO_W      = 8;
    localparam int HALF_PERIOD = 20;

    // Watchdog budget
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int MARGIN_CYCLES   = 100;

    // Bounds for reply waits and polling loops
    localparam int MAX_WAIT   = 8;
    localparam int POLL_LIMIT = 16;

    logic                   clk_i;
    logic                   reset_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    sel_t                   wb_sel_i;
    adr_t                   wb_adr_i;
    word_t                  wb_dat_i;
    word_t                  wb_dat_o;
    logic                   wb_ack_o;
    logic                   wb_err_o;
    logic [IRQ_SOURCES-1:0] irq_src_i;
    logic                   irq_o;
    logic [GPIO_W-1:0]      gpio_i;
    logic [GPIO_W-1:0]      gpio_o;
    logic [GPIO_W-1:0]      gpio_oe_o;

    integer seed = 32'hd508;

    wb_subsys_top #(
        .RAM_DEPTH   ( RAM_DEPTH   ),
        .IRQ_SOURCES ( IRQ_SOURCES ),
        .GPIO_W      ( GPIO_W      )
    ) dut (
        .clk_i     ( clk_i     ),
        .reset_i   ( reset_i   ),
        .wb_cyc_i  ( wb_cyc_i  ),
        .wb_stb_i  ( wb_stb_i  ),
        .wb_we_i   ( wb_we_i   ),
        .wb_sel_i  ( wb_sel_i  ),
        .wb_adr_i  ( wb_adr_i  ),
        .wb_dat_i  ( wb_dat_i  ),
        .wb_dat_o  ( wb_dat_o  ),
        .wb_ack_o  ( wb_ack_o  ),
        .wb_err_o  ( wb_err_o  ),
        .irq_src_i ( irq_src_i ),
        .irq_o     ( irq_o     ),
        .gpio_i    ( gpio_i    ),
        .gpio_o    ( gpio_o    ),
        .gpio_oe_o ( gpio_oe_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD clk_i = ~clk_i;
    end

    // Reports the reason, then ends the run
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    `include "tb_wb_tasks.svh"

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES) @(posedge clk_i);
        fail_run("Timeout: the directed tests did not finish within the cycle budget");
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        reset_i   = 1'b1;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_sel_i  = '0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        irq_src_i = '0;
        gpio_i    = '0;

        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;

        test_reset_state();
        test_ram_lanes();
        test_unmapped();
        test_gpio();
        test_interrupts();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== wb_subsys.f ====
+incdir+sim
rtl/wb_subsys_pkg.sv
rtl/wb_bus_if.sv
rtl/wb_addr_decoder.sv
rtl/data_ram.sv
rtl/irq_capture.sv
rtl/irq_regs.sv
rtl/gpio_regs.sv
rtl/wb_subsys_top.sv
sim/tb_wb_subsys.sv
